//--- Makefile
RTL = design/mmu_pkg.sv design/dtlb.sv design/page_walker.sv design/lsu_translate.sv \
      design/mmu_top.sv

.PHONY: all lint clean

all: obj_dir/Vmmu_tb
	./obj_dir/Vmmu_tb > sim.log 2>&1 ; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then \
		echo "simulation reported failure, see sim.log"; exit 1; \
	fi

obj_dir/Vmmu_tb: mmu_top.f $(RTL) tests/mmu_tb.sv tests/mmu_props.sv
	verilator --binary --timing --assert -j 0 --top-module mmu_tb -f mmu_top.f

lint:
	verilator --lint-only -Wall --top-module mmu_top $(RTL)

clean:
	rm -rf obj_dir sim.log

//--- design/dtlb.sv
// Data TLB
// fully associative translation cache for 4K, 2M and 1G pages with a
// combinational lookup, round-robin fill and flush of all entries

`timescale 1ns/10ps

module dtlb #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  mmu_pkg::tlb_update_t     update_i,
    input  logic [mmu_pkg::VLEN-1:0] lu_vaddr_i,
    output mmu_pkg::tlb_lookup_t     lookup_o
);
    import mmu_pkg::*;

    localparam int unsigned IDX_W = $clog2(DTLB_ENTRIES);

    typedef struct packed {
        logic [VPNW-1:0] vpn;
        logic            is_2m;
        logic            is_1g;
        pte_t            pte;
    } tlb_entry_t;

    tlb_entry_t              entry_q [DTLB_ENTRIES];
    logic [DTLB_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]        rr_ptr_q;
    logic [DTLB_ENTRIES-1:0] match;
    logic [VPNW-1:0]         lu_vpn;

    assign lu_vpn = lu_vaddr_i[VLEN-1:PAGE_OFFSET_W];

    // ------------------------------
    // tag compare
    // ------------------------------
    for (genvar i = 0; i < DTLB_ENTRIES; i++) begin : gen_match
        logic vpn2_eq;
        logic vpn1_eq;
        logic vpn0_eq;

        assign vpn2_eq = entry_q[i].vpn[2*VPN_IDX_W +: VPN_IDX_W] ==
                         lu_vpn[2*VPN_IDX_W +: VPN_IDX_W];
        assign vpn1_eq = entry_q[i].vpn[VPN_IDX_W +: VPN_IDX_W] ==
                         lu_vpn[VPN_IDX_W +: VPN_IDX_W];
        assign vpn0_eq = entry_q[i].vpn[0 +: VPN_IDX_W] == lu_vpn[0 +: VPN_IDX_W];

        // superpages ignore the lower vpn fields
        assign match[i] = valid_q[i] && vpn2_eq &&
                          (entry_q[i].is_1g || (vpn1_eq && (entry_q[i].is_2m || vpn0_eq)));
    end

    always_comb begin : lookup
        lookup_o = '0;
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            if (match[i]) begin
                lookup_o.hit   = 1'b1;
                lookup_o.is_2m = entry_q[i].is_2m;
                lookup_o.is_1g = entry_q[i].is_1g;
                lookup_o.pte   = entry_q[i].pte;
            end
        end
    end

    // ------------------------------
    // fill and flush
    // ------------------------------
    // flush wins over a fill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[rr_ptr_q] <= 1'b1;
            rr_ptr_q          <= rr_ptr_q + IDX_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            entry_q[rr_ptr_q].vpn   <= update_i.vpn;
            entry_q[rr_ptr_q].is_2m <= update_i.is_2m;
            entry_q[rr_ptr_q].is_1g <= update_i.is_1g;
            entry_q[rr_ptr_q].pte   <= update_i.pte;
        end
    end

endmodule

//--- design/lsu_translate.sv
// Load/store translation stage
// registers the request and TLB lookup, builds the physical address one
// cycle later and raises load or store page faults

`timescale 1ns/10ps

module lsu_translate (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     translation_en_i,
    input  mmu_pkg::priv_lvl_e       ld_st_priv_i,
    input  logic                     sum_i,
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                     lsu_is_store_i,
    input  mmu_pkg::tlb_lookup_t     lookup_i,
    input  logic                     walk_active_i,
    input  logic                     walk_error_i,
    input  logic [mmu_pkg::VLEN-1:0] walk_vaddr_i,
    output logic                     lsu_dtlb_hit_o,
    output logic                     lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0] lsu_paddr_o,
    output mmu_pkg::exception_t      lsu_exception_o
);
    import mmu_pkg::*;

    logic            req_q;
    logic            hit_q;
    logic            is_store_q;
    logic [VLEN-1:0] vaddr_q;
    tlb_lookup_t     lookup_q;
    logic            priv_err;
    logic            perm_err;
    exc_cause_e      fault_cause;

    // with translation off every request is ready at once
    assign lsu_dtlb_hit_o = translation_en_i ? lookup_i.hit : 1'b1;

    // ------------------------------
    // request register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= lsu_dtlb_hit_o;
        end
    end

    always_ff @(posedge clk_i) begin
        is_store_q <= lsu_is_store_i;
        vaddr_q    <= lsu_vaddr_i;
        lookup_q   <= lookup_i;
    end

    // ------------------------------
    // permission checks
    // ------------------------------
    assign priv_err = ((ld_st_priv_i == PRIV_LVL_U) && !lookup_q.pte.u) ||
                      ((ld_st_priv_i == PRIV_LVL_S) && lookup_q.pte.u && !sum_i);

    // stores need w and d set, loads need r
    assign perm_err = priv_err || !lookup_q.pte.a ||
                      (is_store_q ? (!lookup_q.pte.w || !lookup_q.pte.d) : !lookup_q.pte.r);

    assign fault_cause = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;

    always_comb begin : response
        lsu_valid_o           = req_q && hit_q;
        lsu_paddr_o           = {{(PLEN-VLEN){1'b0}}, vaddr_q};
        lsu_exception_o.cause = LOAD_PAGE_FAULT;
        lsu_exception_o.tval  = '0;
        lsu_exception_o.valid = 1'b0;

        if (translation_en_i) begin
            lsu_paddr_o = {lookup_q.pte.ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            // superpages take the low vpn fields from the vaddr
            if (lookup_q.is_2m) begin
                lsu_paddr_o[PAGE_OFFSET_W +: VPN_IDX_W] = vaddr_q[PAGE_OFFSET_W +: VPN_IDX_W];
            end
            if (lookup_q.is_1g) begin
                lsu_paddr_o[PAGE_OFFSET_W +: 2*VPN_IDX_W] =
                    vaddr_q[PAGE_OFFSET_W +: 2*VPN_IDX_W];
            end

            if (req_q && hit_q) begin
                if (perm_err) begin
                    lsu_exception_o.cause = fault_cause;
                    lsu_exception_o.tval  = {{(XLEN-VLEN){1'b0}}, vaddr_q};
                    lsu_exception_o.valid = 1'b1;
                end
            end else if (walk_active_i && walk_error_i) begin
                // failed walk ends the held request
                lsu_valid_o           = 1'b1;
                lsu_exception_o.cause = fault_cause;
                lsu_exception_o.tval  = {{(XLEN-VLEN){1'b0}}, walk_vaddr_i};
                lsu_exception_o.valid = 1'b1;
            end
        end
    end

endmodule

//--- design/mmu_pkg.sv
// Sv39 data MMU shared definitions
// address widths, page table entry layout, TLB fill and lookup records,
// walker memory port and the page fault exception record

package mmu_pkg;

    // ------------------------------
    // Sv39 geometry
    // ------------------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned PLEN          = 56;
    localparam int unsigned PPNW          = 44;
    localparam int unsigned VPNW          = 27;
    localparam int unsigned PT_LEVELS     = 3;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned PTE_SIZE_LOG2 = 3;
    // one VPN field per table level
    localparam int unsigned VPN_IDX_W     = VPNW / PT_LEVELS;

    // page table entry, msb first
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // ------------------------------
    // TLB records
    // ------------------------------
    typedef struct packed {
        logic            valid;
        logic [VPNW-1:0] vpn;
        logic            is_2m;
        logic            is_1g;
        pte_t            pte;
    } tlb_update_t;

    typedef struct packed {
        logic hit;
        logic is_2m;
        logic is_1g;
        pte_t pte;
    } tlb_lookup_t;

    // walker read port, addr held until gnt, data returns with rvalid
    typedef struct packed {
        logic            req;
        logic [PLEN-1:0] addr;
    } ptw_mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
    } ptw_mem_rsp_t;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_e;

    typedef enum logic [5:0] {
        LOAD_PAGE_FAULT  = 6'd13,
        STORE_PAGE_FAULT = 6'd15
    } exc_cause_e;

    typedef struct packed {
        exc_cause_e      cause;
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception_t;

endpackage

//--- design/mmu_top.sv
// Data MMU top level
// Sv39 load/store translation built from the data TLB, the page table
// walker and the registered translation stage

`timescale 1ns/10ps

module mmu_top #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     translation_en_i,
    input  mmu_pkg::priv_lvl_e       ld_st_priv_i,
    input  logic                     sum_i,
    input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
    // load/store request and response
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                     lsu_is_store_i,
    output logic                     lsu_dtlb_hit_o,
    output logic                     lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0] lsu_paddr_o,
    output mmu_pkg::exception_t      lsu_exception_o,
    output logic                     dtlb_miss_o,
    // walker memory port
    output mmu_pkg::ptw_mem_req_t    mem_req_o,
    input  mmu_pkg::ptw_mem_rsp_t    mem_rsp_i
);
    import mmu_pkg::*;

    tlb_update_t     dtlb_update;
    tlb_lookup_t     dtlb_lookup;
    logic            walk_active;
    logic            walk_error;
    logic [VLEN-1:0] walk_vaddr;

    dtlb #(
        .DTLB_ENTRIES ( DTLB_ENTRIES )
    ) i_dtlb (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_i     ),
        .update_i   ( dtlb_update ),
        .lu_vaddr_i ( lsu_vaddr_i ),
        .lookup_o   ( dtlb_lookup )
    );

    page_walker i_page_walker (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .translation_en_i ( translation_en_i ),
        .satp_ppn_i       ( satp_ppn_i       ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lookup_i         ( dtlb_lookup      ),
        .mem_req_o        ( mem_req_o        ),
        .mem_rsp_i        ( mem_rsp_i        ),
        .update_o         ( dtlb_update      ),
        .walk_active_o    ( walk_active      ),
        .walk_error_o     ( walk_error       ),
        .walk_vaddr_o     ( walk_vaddr       ),
        .dtlb_miss_o      ( dtlb_miss_o      )
    );

    lsu_translate i_lsu_translate (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .translation_en_i ( translation_en_i ),
        .ld_st_priv_i     ( ld_st_priv_i     ),
        .sum_i            ( sum_i            ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lsu_is_store_i   ( lsu_is_store_i   ),
        .lookup_i         ( dtlb_lookup      ),
        .walk_active_i    ( walk_active      ),
        .walk_error_i     ( walk_error       ),
        .walk_vaddr_i     ( walk_vaddr       ),
        .lsu_dtlb_hit_o   ( lsu_dtlb_hit_o   ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .lsu_paddr_o      ( lsu_paddr_o      ),
        .lsu_exception_o  ( lsu_exception_o  )
    );

endmodule

//--- design/page_walker.sv
// Sv39 page table walker
// walks levels 2, 1 and 0 on a data TLB miss, reading one PTE per level
// through the memory port, and ends in a TLB fill or a page fault

`timescale 1ns/10ps

module page_walker (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     translation_en_i,
    input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  mmu_pkg::tlb_lookup_t     lookup_i,
    output mmu_pkg::ptw_mem_req_t    mem_req_o,
    input  mmu_pkg::ptw_mem_rsp_t    mem_rsp_i,
    output mmu_pkg::tlb_update_t     update_o,
    output logic                     walk_active_o,
    output logic                     walk_error_o,
    output logic [mmu_pkg::VLEN-1:0] walk_vaddr_o,
    output logic                     dtlb_miss_o
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

    walk_state_e          state_q, state_d;
    logic [1:0]           level_q, level_d;
    logic                 miss_q, miss_d;
    logic [PPNW-1:0]      ptr_q, ptr_d;
    logic [VLEN-1:0]      vaddr_q, vaddr_d;
    logic [VPN_IDX_W-1:0] vpn_idx;
    pte_t                 pte;
    logic                 superpage_misaligned;

    assign pte = pte_t'(mem_rsp_i.rdata);

    // table index for the current level
    assign vpn_idx = vaddr_q[PAGE_OFFSET_W + level_q * VPN_IDX_W +: VPN_IDX_W];

    // a superpage leaf needs its low ppn fields clear
    assign superpage_misaligned =
        ((level_q == 2'd2) && (|pte.ppn[2*VPN_IDX_W-1:0])) ||
        ((level_q == 2'd1) && (|pte.ppn[VPN_IDX_W-1:0]));

    assign walk_active_o = (state_q != IDLE);
    assign walk_error_o  = (state_q == PROPAGATE_ERROR);
    assign walk_vaddr_o  = vaddr_q;
    assign dtlb_miss_o   = miss_q;

    // ------------------------------
    // walk FSM
    // ------------------------------
    always_comb begin : walk_fsm
        state_d        = state_q;
        level_d        = level_q;
        ptr_d          = ptr_q;
        vaddr_d        = vaddr_q;
        miss_d         = 1'b0;
        mem_req_o.req  = 1'b0;
        mem_req_o.addr = {ptr_q, vpn_idx, {PTE_SIZE_LOG2{1'b0}}};
        update_o.valid = 1'b0;
        update_o.vpn   = vaddr_q[VLEN-1:PAGE_OFFSET_W];
        update_o.is_1g = (level_q == 2'd2);
        update_o.is_2m = (level_q == 2'd1);
        update_o.pte   = pte;

        case (state_q)
            IDLE: begin
                if (translation_en_i && lsu_req_i && !lookup_i.hit) begin
                    state_d = WAIT_GRANT;
                    level_d = 2'(PT_LEVELS - 1);
                    ptr_d   = satp_ppn_i;
                    vaddr_d = lsu_vaddr_i;
                    miss_d  = 1'b1;
                end
            end
            WAIT_GRANT: begin
                mem_req_o.req = 1'b1;
                if (mem_rsp_i.gnt) begin
                    state_d = WAIT_RVALID;
                end
            end
            WAIT_RVALID: begin
                if (mem_rsp_i.rvalid) begin
                    if (!pte.v || (pte.w && !pte.r)) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (pte.r || pte.x) begin
                        // leaf, its level sets the page size
                        if (superpage_misaligned) begin
                            state_d = PROPAGATE_ERROR;
                        end else begin
                            update_o.valid = 1'b1;
                            state_d        = IDLE;
                        end
                    end else if (level_q == 2'd0) begin
                        state_d = PROPAGATE_ERROR;
                    end else begin
                        // pointer to the next table
                        ptr_d   = pte.ppn;
                        level_d = level_q - 2'd1;
                        state_d = WAIT_GRANT;
                    end
                end
            end
            PROPAGATE_ERROR: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= '0;
            miss_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
            miss_q  <= miss_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ptr_q   <= ptr_d;
        vaddr_q <= vaddr_d;
    end

endmodule

//--- mmu_top.f
design/mmu_pkg.sv
design/dtlb.sv
design/page_walker.sv
design/lsu_translate.sv
design/mmu_top.sv
tests/mmu_props.sv
tests/mmu_tb.sv

//--- tests/mmu_props.sv
// Data MMU protocol assertions
// memory port stability, response timing and exception qualification

`timescale 1ns/10ps

module mmu_props (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  lsu_req_i,
    input logic                  lsu_dtlb_hit_i,
    input logic                  lsu_valid_i,
    input logic                  walk_error_i,
    input mmu_pkg::exception_t   lsu_exception_i,
    input mmu_pkg::ptw_mem_req_t mem_req_i,
    input mmu_pkg::ptw_mem_rsp_t mem_rsp_i
);

    // walker keeps its read request and address until granted
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.req && !mem_rsp_i.gnt |=> mem_req_i.req && $stable(mem_req_i.addr))
        else $error("memory request dropped or changed before grant");

    // a response follows a hitting request or ends a failed walk
    valid_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i |-> $past(lsu_req_i && lsu_dtlb_hit_i) || walk_error_i)
        else $error("lsu_valid_o without a hitting request or walk error");

    exc_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exception_i.valid |-> lsu_valid_i)
        else $error("lsu_exception_o.valid without lsu_valid_o");

endmodule

//--- tests/mmu_tb.sv
// Data MMU testbench
// page tables in a sparse memory model, a reference Sv39 walk for the
// expected paddr and fault, and directed load/store requests

`timescale 1ns/10ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int NUM_REQS       = 21;
    localparam int TIMEOUT_CYCLES = 16 + NUM_REQS * 200;
    localparam logic [PPNW-1:0] ROOT_PPN = 44'h80000;
    localparam logic [PPNW-1:0] L1_PPN   = 44'h80001;
    localparam logic [PPNW-1:0] L0_PPN   = 44'h80002;
    // flag bytes, bit order d a g u x w r v
    localparam logic [7:0] PTR    = 8'h01;
    localparam logic [7:0] RW_S   = 8'hC7;
    localparam logic [7:0] RW_U   = 8'hD7;
    localparam logic [7:0] RO_U   = 8'h53;
    localparam logic [7:0] NOD_U  = 8'h57;
    localparam logic [7:0] W_ONLY = 8'hC5;

    typedef struct packed {
        logic [VLEN-1:0] vaddr;
        logic            is_store;
        priv_lvl_e       priv;
        logic            sum;
        logic            trans_en;
    } req_rec_t;

    typedef struct packed {
        logic [PLEN-1:0] paddr;
        exception_t      exc;
    } exp_rsp_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            flush;
    logic            translation_en;
    priv_lvl_e       priv;
    logic            sum;
    logic [PPNW-1:0] satp_ppn;
    logic            lsu_req;
    logic [VLEN-1:0] lsu_vaddr;
    logic            lsu_is_store;
    logic            lsu_dtlb_hit;
    logic            lsu_valid;
    logic [PLEN-1:0] lsu_paddr;
    exception_t      lsu_exception;
    logic            dtlb_miss;
    ptw_mem_req_t    mem_req;
    ptw_mem_rsp_t    mem_rsp;

    logic [63:0] mem [logic [PLEN-1:0]];
    req_rec_t    pending_q [$];
    int          errors    = 0;
    int          requests  = 0;
    int          responses = 0;
    int          cycles    = 0;
    logic [15:0] lfsr_q    = 16'd8;

    mmu_top #(
        .DTLB_ENTRIES ( 4 )
    ) uut (
        .clk_i            ( clk            ),
        .rst_ni           ( rst_n          ),
        .flush_i          ( flush          ),
        .translation_en_i ( translation_en ),
        .ld_st_priv_i     ( priv           ),
        .sum_i            ( sum            ),
        .satp_ppn_i       ( satp_ppn       ),
        .lsu_req_i        ( lsu_req        ),
        .lsu_vaddr_i      ( lsu_vaddr      ),
        .lsu_is_store_i   ( lsu_is_store   ),
        .lsu_dtlb_hit_o   ( lsu_dtlb_hit   ),
        .lsu_valid_o      ( lsu_valid      ),
        .lsu_paddr_o      ( lsu_paddr      ),
        .lsu_exception_o  ( lsu_exception  ),
        .dtlb_miss_o      ( dtlb_miss      ),
        .mem_req_o        ( mem_req        ),
        .mem_rsp_i        ( mem_rsp        )
    );

    bind mmu_top mmu_props i_props (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .lsu_req_i       ( lsu_req_i       ),
        .lsu_dtlb_hit_i  ( lsu_dtlb_hit_o  ),
        .lsu_valid_i     ( lsu_valid_o     ),
        .walk_error_i    ( walk_error      ),
        .lsu_exception_i ( lsu_exception_o ),
        .mem_req_i       ( mem_req_o       ),
        .mem_rsp_i       ( mem_rsp_i       )
    );

    always #20 clk = ~clk;

    // ------------------------------
    // helpers
    // ------------------------------
    // 16 bit Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int unsigned rand_bits(int unsigned n);
        int unsigned val;
        val = 0;
        for (int unsigned i = 0; i < n; i++) begin
            val = (val << 1) | 32'(lfsr_bit());
        end
        return val;
    endfunction

    function automatic logic [63:0] read_mem(logic [PLEN-1:0] addr);
        return mem.exists(addr) ? mem[addr] : 64'd0;
    endfunction

    function automatic void set_pte(logic [PPNW-1:0] tbl, logic [8:0] idx,
                                    logic [PPNW-1:0] ppn, logic [7:0] flags);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        mem[{tbl, idx, 3'b000}] = 64'(p);
    endfunction

    // Sv39 walk over the memory model with the permission rules
    function automatic exp_rsp_t expected_translation(req_rec_t rq);
        exp_rsp_t        rsp;
        logic [PPNW-1:0] ptr;
        pte_t            pte;
        logic            fault;
        int              lvl;
        rsp.paddr     = {{(PLEN-VLEN){1'b0}}, rq.vaddr};
        rsp.exc.cause = rq.is_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        rsp.exc.tval  = {{(XLEN-VLEN){1'b0}}, rq.vaddr};
        rsp.exc.valid = 1'b0;
        if (!rq.trans_en) begin
            return rsp;
        end
        ptr   = satp_ppn;
        fault = 1'b1;
        for (lvl = 2; lvl >= 0; lvl--) begin
            pte = pte_t'(read_mem({ptr, rq.vaddr[PAGE_OFFSET_W + VPN_IDX_W * lvl +: VPN_IDX_W],
                                   3'b000}));
            if (!pte.v || (pte.w && !pte.r)) begin
                break;
            end
            if (pte.r || pte.x) begin
                if ((lvl == 2 && |pte.ppn[2*VPN_IDX_W-1:0]) ||
                    (lvl == 1 && |pte.ppn[VPN_IDX_W-1:0])) begin
                    break;
                end
                rsp.paddr = {pte.ppn, rq.vaddr[PAGE_OFFSET_W-1:0]};
                // low vpn fields come from the vaddr on superpages
                if (lvl >= 1) begin
                    rsp.paddr[PAGE_OFFSET_W +: VPN_IDX_W] = rq.vaddr[PAGE_OFFSET_W +: VPN_IDX_W];
                end
                if (lvl == 2) begin
                    rsp.paddr[PAGE_OFFSET_W + VPN_IDX_W +: VPN_IDX_W] =
                        rq.vaddr[PAGE_OFFSET_W + VPN_IDX_W +: VPN_IDX_W];
                end
                fault = (rq.priv == PRIV_LVL_U && !pte.u) ||
                        (rq.priv == PRIV_LVL_S && pte.u && !rq.sum) || !pte.a ||
                        (rq.is_store ? (!pte.w || !pte.d) : !pte.r);
                break;
            end
            if (lvl == 0) begin
                break;
            end
            ptr = pte.ppn;
        end
        rsp.exc.valid = fault;
        return rsp;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    // one request held until lsu_valid_o
    task automatic access(input logic [VLEN-1:0] vaddr, input logic is_store,
                          input priv_lvl_e lvl, input logic sum_en, input int exp_misses);
        req_rec_t rec;
        int       latency;
        int       misses;
        @(negedge clk);
        rec.vaddr    = vaddr;
        rec.is_store = is_store;
        rec.priv     = lvl;
        rec.sum      = sum_en;
        rec.trans_en = translation_en;
        pending_q.push_back(rec);
        requests++;
        lsu_vaddr    = vaddr;
        lsu_is_store = is_store;
        priv         = lvl;
        sum          = sum_en;
        lsu_req      = 1'b1;
        latency      = 0;
        misses       = 0;
        do begin
            @(negedge clk);
            latency++;
            // a request that needs no walk hits from its first cycle
            if (latency == 1) begin
                check("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit), 64'(exp_misses == 0));
            end
            if (dtlb_miss) begin
                misses++;
            end
        end while (!lsu_valid);
        lsu_req = 1'b0;
        check("dtlb_miss_o pulses", 64'(misses), 64'(exp_misses));
        if (exp_misses == 0) begin
            check("response latency", 64'(latency), 64'd1);
        end
    endtask

    // ------------------------------
    // memory model
    // ------------------------------
    initial begin : mem_model
        int unsigned     wait_cnt;
        logic            counting;
        logic            pending;
        logic [PLEN-1:0] pend_addr;
        wait_cnt  = 0;
        counting  = 1'b0;
        pending   = 1'b0;
        pend_addr = '0;
        mem_rsp   = '0;
        forever begin
            @(negedge clk);
            mem_rsp.gnt    = 1'b0;
            mem_rsp.rvalid = 1'b0;
            if (pending) begin
                mem_rsp.rvalid = 1'b1;
                mem_rsp.rdata  = read_mem(pend_addr);
                pending        = 1'b0;
            end else if (mem_req.req) begin
                if (!counting) begin
                    wait_cnt = rand_bits(2);
                    counting = 1'b1;
                end
                if (wait_cnt == 0) begin
                    mem_rsp.gnt = 1'b1;
                    pend_addr   = mem_req.addr;
                    pending     = 1'b1;
                    counting    = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    always @(negedge clk) begin : compare
        req_rec_t rec;
        exp_rsp_t want;
        if (rst_n && lsu_valid) begin
            if (pending_q.size() == 0) begin
                errors++;
                $display("response at %0t with no request outstanding", $time);
            end else begin
                rec  = pending_q.pop_front();
                want = expected_translation(rec);
                responses++;
                check("lsu_exception_o.valid", 64'(lsu_exception.valid), 64'(want.exc.valid));
                if (want.exc.valid) begin
                    check("lsu_exception_o.cause", 64'(lsu_exception.cause), 64'(want.exc.cause));
                    check("lsu_exception_o.tval", lsu_exception.tval, want.exc.tval);
                end else begin
                    check("lsu_paddr_o", 64'(lsu_paddr), 64'(want.paddr));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request got no response", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus
        rst_n          = 1'b0;
        flush          = 1'b0;
        translation_en = 1'b0;
        priv           = PRIV_LVL_S;
        sum            = 1'b0;
        satp_ppn       = ROOT_PPN;
        lsu_req        = 1'b0;
        lsu_vaddr      = '0;
        lsu_is_store   = 1'b0;
        set_pte(ROOT_PPN, 9'd0, L1_PPN, PTR);
        set_pte(ROOT_PPN, 9'd1, 44'hC0000, RW_S);
        set_pte(ROOT_PPN, 9'd2, 44'hC0001, RW_S);
        set_pte(L1_PPN, 9'd0, L0_PPN, PTR);
        set_pte(L1_PPN, 9'd1, 44'h40200, RW_S);
        set_pte(L1_PPN, 9'd2, 44'h40201, RW_S);
        set_pte(L0_PPN, 9'd1, 44'h12345, RW_S);
        set_pte(L0_PPN, 9'd2, 44'h23456, RW_U);
        set_pte(L0_PPN, 9'd3, 44'h34567, RO_U);
        set_pte(L0_PPN, 9'd4, 44'h45678, NOD_U);
        set_pte(L0_PPN, 9'd6, 44'h80003, PTR);
        set_pte(L0_PPN, 9'd7, 44'h56789, W_ONLY);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // bare mode
        access(39'h00_0000_1234, 1'b0, PRIV_LVL_S, 1'b0, 0);
        access(39'h7F_FFFF_FFF8, 1'b1, PRIV_LVL_S, 1'b0, 0);
        access(39'h01_2345_6780, 1'b0, PRIV_LVL_U, 1'b0, 0);

        @(negedge clk);
        translation_en = 1'b1;
        // 4K, 2M and 1G leaves, then permission faults
        access(39'h00_0000_1abc, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0000_1ff0, 1'b1, PRIV_LVL_S, 1'b0, 0);
        access(39'h00_0020_3456, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_4123_4567, 1'b1, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0000_1000, 1'b0, PRIV_LVL_U, 1'b0, 0);
        access(39'h00_0000_2010, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0000_2018, 1'b0, PRIV_LVL_S, 1'b1, 0);
        access(39'h00_0000_2020, 1'b0, PRIV_LVL_U, 1'b0, 0);
        access(39'h00_0000_3000, 1'b1, PRIV_LVL_U, 1'b0, 1);
        access(39'h00_0000_4008, 1'b1, PRIV_LVL_U, 1'b0, 1);
        access(39'h00_0000_4010, 1'b0, PRIV_LVL_U, 1'b0, 0);

        // walks that end in a page fault
        access(39'h00_0000_5000, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0040_0000, 1'b1, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_8000_0000, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0000_6000, 1'b0, PRIV_LVL_S, 1'b0, 1);
        access(39'h00_0000_7000, 1'b1, PRIV_LVL_S, 1'b0, 1);

        // cached 1G page walks again after a flush
        access(39'h00_4000_0010, 1'b0, PRIV_LVL_S, 1'b0, 0);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        access(39'h00_4000_0010, 1'b0, PRIV_LVL_S, 1'b0, 1);

        repeat (4) @(negedge clk);
        check("responses", 64'(responses), 64'(requests));
        $display("done: %0d requests, %0d responses, %0d errors", requests, responses, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
